/* src/lsu_cfg.svh */
// Size definitions for the load/store unit, included by the RTL and the bench.
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data path width.
`define LSU_XLEN 64

// Request tag width.
`define LSU_TAG_W 4

// Request queue depth, also the credits the issue side starts with.
`define LSU_REQ_DEPTH 4

// Response credits held by the unit after reset.
`define LSU_RSP_CREDITS 2

// Data memory size in 64-bit words. Index is addr[..:3] modulo this.
`define LSU_MEM_WORDS 256

`endif

/* src/lsu_pkg.sv */
// Shared request, response, register and state types; import into any LSU module.
`include "lsu_cfg.svh"

package lsu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Memory op, stores look at the size only.
  typedef enum logic [2:0] {
    BYTE_S = 3'd0,
    BYTE_U = 3'd1,
    HALF_S = 3'd2,
    HALF_U = 3'd3,
    WORD_S = 3'd4,
    WORD_U = 3'd5,
    DOUBLE = 3'd6,
    NONE   = 3'd7
  } mem_op_e;

  typedef enum logic [1:0] {IDLE, ACCESS, RESP} lsu_state_e;

  typedef enum logic [1:0] {
    REG_CTRL       = 2'd0,
    REG_FAULT_CNT  = 2'd1,
    REG_FAULT_ADDR = 2'd2
  } reg_addr_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Channel and sideband types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic                  is_store;
    mem_op_e               op;
    logic [`LSU_XLEN-1:0]  addr;
    logic [`LSU_XLEN-1:0]  wdata;
    logic [`LSU_TAG_W-1:0] tag;
  } lsu_req_t;

  typedef struct packed {
    logic [`LSU_TAG_W-1:0] tag;
    logic [`LSU_XLEN-1:0]  rdata;
    logic                  fault;
  } lsu_rsp_t;

  typedef struct packed {
    logic enable;
  } lsu_cfg_t;

  typedef struct packed {
    logic                 valid;
    logic [`LSU_XLEN-1:0] addr;
  } lsu_fault_t;

endpackage

/* src/lsu_req_fifo.sv */
// Request queue; holds issued requests and hands back one request credit per dequeue.
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_req_fifo import lsu_pkg::*; (
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  logic     i_push,
  input  lsu_req_t i_data,
  input  logic     i_pop,
  output lsu_req_t o_head,
  output logic     o_head_valid,
  output logic     o_credit
);

  localparam int DEPTH = `LSU_REQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_req_t         entries [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  assign do_pop       = i_pop && (count != '0);
  assign o_head       = entries[rd_ptr];
  assign o_head_valid = (count != '0);
  assign o_credit     = do_pop; // Slot freed, credit goes back now.

  // Payload only, no reset.
  always_ff @(posedge i_clk) begin
    if (i_push) entries[wr_ptr] <= i_data;
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone.
      if (i_push && !do_pop)      count <= count + 1'b1;
      else if (!i_push && do_pop) count <= count - 1'b1;
    end
  end

endmodule

/* src/lsu_align.sv */
// Store lane and mask builder plus load field extraction; purely combinational.
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_align import lsu_pkg::*; (
  input  lsu_req_t                           i_req,
  input  logic [`LSU_XLEN-1:0]               i_rword,
  output logic [$clog2(`LSU_MEM_WORDS)-1:0]  o_index,
  output logic [`LSU_XLEN-1:0]               o_wdata,
  output logic [7:0]                         o_wmask,
  output logic [`LSU_XLEN-1:0]               o_rdata,
  output logic                               o_misaligned
);

  localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
  localparam int XL    = `LSU_XLEN;

  logic [2:0]    offs;
  logic [7:0]    base_mask;
  logic [2:0]    low_bits; // Address bits that must be zero for this size.
  logic [XL-1:0] shifted;

  assign offs    = i_req.addr[2:0];
  assign o_index = i_req.addr[3 +: IDX_W];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Size decode and alignment check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    base_mask = 8'h00;
    low_bits  = 3'b000;
    case (i_req.op)
      BYTE_S, BYTE_U: base_mask = 8'h01;
      HALF_S, HALF_U: begin
        base_mask = 8'h03;
        low_bits  = 3'b001;
      end
      WORD_S, WORD_U: begin
        base_mask = 8'h0f;
        low_bits  = 3'b011;
      end
      DOUBLE: begin
        base_mask = 8'hff;
        low_bits  = 3'b111;
      end
      default: base_mask = 8'h00;
    endcase
  end

  assign o_misaligned = (i_req.op == NONE) || ((offs & low_bits) != 3'b000);

  // Empty mask on a bad access, so nothing can land in memory.
  assign o_wmask = o_misaligned ? 8'h00 : (base_mask << offs);
  assign o_wdata = i_req.wdata << {offs, 3'b000};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Load extraction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign shifted = i_rword >> {offs, 3'b000}; // Field down to bit 0.

  always_comb begin
    case (i_req.op)
      BYTE_S:  o_rdata = {{(XL-8){shifted[7]}}, shifted[7:0]};
      BYTE_U:  o_rdata = {{(XL-8){1'b0}}, shifted[7:0]};
      HALF_S:  o_rdata = {{(XL-16){shifted[15]}}, shifted[15:0]};
      HALF_U:  o_rdata = {{(XL-16){1'b0}}, shifted[15:0]};
      WORD_S:  o_rdata = {{(XL-32){shifted[31]}}, shifted[31:0]};
      WORD_U:  o_rdata = {{(XL-32){1'b0}}, shifted[31:0]};
      DOUBLE:  o_rdata = shifted;
      default: o_rdata = '0;
    endcase
  end

endmodule

/* src/lsu_ctrl.sv */
// Access FSM; sequences one memory access per request and returns credited responses.
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_ctrl import lsu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  lsu_req_t             i_head,
  input  logic                 i_head_valid,
  output logic                 o_pop,
  input  lsu_cfg_t             i_cfg,
  input  logic                 i_misaligned,
  input  logic [`LSU_XLEN-1:0] i_ext_data,
  output logic                 o_mem_we,
  output logic                 o_mem_re,
  output lsu_fault_t           o_fault,
  output logic                 o_rsp_valid,
  output lsu_rsp_t             o_rsp,
  input  logic                 i_rsp_credit
);

  localparam int CRED_W = $clog2(`LSU_RSP_CREDITS + 1);

  lsu_state_e        state;
  lsu_state_e        state_nxt;
  logic [CRED_W-1:0] rsp_cred;
  logic              in_resp;
  logic              start;

  assign in_resp = (state == RESP);
  assign start   = i_head_valid && i_cfg.enable && (rsp_cred != '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (start) state_nxt = ACCESS;
      ACCESS:  state_nxt = RESP;
      RESP:    state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= IDLE;
      rsp_cred <= CRED_W'(`LSU_RSP_CREDITS);
    end else begin
      state <= state_nxt;
      // Spend and refund in one cycle cancel out.
      if (in_resp && !i_rsp_credit)      rsp_cred <= rsp_cred - 1'b1;
      else if (!in_resp && i_rsp_credit) rsp_cred <= rsp_cred + 1'b1;
    end
  end

  // Memory is only touched by a well-formed access.
  assign o_mem_we = (state == ACCESS) && i_head.is_store && !i_misaligned;
  assign o_mem_re = (state == ACCESS) && !i_head.is_store && !i_misaligned;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response and fault event
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign o_pop       = in_resp; // Head leaves the queue with its response.
  assign o_rsp_valid = in_resp;

  always_comb begin
    o_rsp.tag   = i_head.tag;
    o_rsp.fault = i_misaligned;
    // Stores and faults return zero data.
    if (i_head.is_store || i_misaligned) o_rsp.rdata = '0;
    else                                 o_rsp.rdata = i_ext_data;
  end

  assign o_fault.valid = in_resp && i_misaligned;
  assign o_fault.addr  = i_head.addr;

endmodule

/* src/lsu_dmem.sv */
// Private data memory with byte-lane writes and a one-cycle registered read.
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_dmem (
  input  logic                              i_clk,
  input  logic                              i_we,
  input  logic                              i_re,
  input  logic [$clog2(`LSU_MEM_WORDS)-1:0] i_index,
  input  logic [`LSU_XLEN-1:0]              i_wdata,
  input  logic [7:0]                        i_wmask,
  output logic [`LSU_XLEN-1:0]              o_rdata
);

  logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      for (int b = 0; b < 8; b++) begin
        if (i_wmask[b]) mem[i_index][b*8 +: 8] <= i_wdata[b*8 +: 8];
      end
    end
    if (i_re) o_rdata <= mem[i_index]; // Held until the next read.
  end

endmodule

/* src/lsu_regs.sv */
// Control and status registers; enable for the FSM, fault count and last fault address.
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_regs import lsu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_we,
  input  reg_addr_e            i_addr,
  input  logic [`LSU_XLEN-1:0] i_wdata,
  output logic [`LSU_XLEN-1:0] o_rdata,
  output lsu_cfg_t             o_cfg,
  input  lsu_fault_t           i_fault
);

  logic                 enable;
  logic [`LSU_XLEN-1:0] fault_cnt;
  logic [`LSU_XLEN-1:0] fault_addr;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      enable     <= 1'b0;
      fault_cnt  <= '0;
      fault_addr <= '0;
    end else begin
      if (i_we && (i_addr == REG_CTRL)) enable <= i_wdata[0];
      if (i_fault.valid) begin
        fault_addr <= i_fault.addr;
        if (fault_cnt != '1) fault_cnt <= fault_cnt + 1'b1; // Saturates.
      end
    end
  end

  assign o_cfg.enable = enable;

  // Read mux, unmapped address reads zero.
  always_comb begin
    case (i_addr)
      REG_CTRL:       o_rdata = {{(`LSU_XLEN-1){1'b0}}, enable};
      REG_FAULT_CNT:  o_rdata = fault_cnt;
      REG_FAULT_ADDR: o_rdata = fault_addr;
      default:        o_rdata = '0;
    endcase
  end

endmodule

/* src/lsu_top.sv */
// Load/store unit top; wires the request queue, FSM, aligner, data memory and registers.
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_req_valid,
  input  lsu_req_t             i_req,
  output logic                 o_req_credit,
  output logic                 o_rsp_valid,
  output lsu_rsp_t             o_rsp,
  input  logic                 i_rsp_credit,
  input  logic                 i_cfg_we,
  input  reg_addr_e            i_cfg_addr,
  input  logic [`LSU_XLEN-1:0] i_cfg_wdata,
  output logic [`LSU_XLEN-1:0] o_cfg_rdata
);

  localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

  lsu_req_t             head;
  logic                 head_valid;
  logic                 pop;
  logic                 misaligned;
  logic [`LSU_XLEN-1:0] ext_data;
  logic                 mem_we;
  logic                 mem_re;
  logic [IDX_W-1:0]     mem_index;
  logic [`LSU_XLEN-1:0] mem_wdata;
  logic [7:0]           mem_wmask;
  logic [`LSU_XLEN-1:0] mem_rword;
  lsu_cfg_t             cfg;
  lsu_fault_t           fault;

  lsu_req_fifo u_req_fifo (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_push       (i_req_valid),
    .i_data       (i_req),
    .i_pop        (pop),
    .o_head       (head),
    .o_head_valid (head_valid),
    .o_credit     (o_req_credit)
  );

  lsu_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_head       (head),
    .i_head_valid (head_valid),
    .o_pop        (pop),
    .i_cfg        (cfg),
    .i_misaligned (misaligned),
    .i_ext_data   (ext_data),
    .o_mem_we     (mem_we),
    .o_mem_re     (mem_re),
    .o_fault      (fault),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp        (o_rsp),
    .i_rsp_credit (i_rsp_credit)
  );

  lsu_align u_align (
    .i_req        (head),
    .i_rword      (mem_rword),
    .o_index      (mem_index),
    .o_wdata      (mem_wdata),
    .o_wmask      (mem_wmask),
    .o_rdata      (ext_data),
    .o_misaligned (misaligned)
  );

  lsu_dmem u_dmem (
    .i_clk   (i_clk),
    .i_we    (mem_we),
    .i_re    (mem_re),
    .i_index (mem_index),
    .i_wdata (mem_wdata),
    .i_wmask (mem_wmask),
    .o_rdata (mem_rword)
  );

  lsu_regs u_regs (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_we     (i_cfg_we),
    .i_addr   (i_cfg_addr),
    .i_wdata  (i_cfg_wdata),
    .o_rdata  (o_cfg_rdata),
    .o_cfg    (cfg),
    .i_fault  (fault)
  );

endmodule

/* bench/lsu_clkgen.sv */
// Testbench clock and reset source; 10 ns clock, reset held low for the first 4 cycles.
`timescale 1ns/1ns

module lsu_clkgen (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (4) @(posedge o_clk);
    #1 o_arst_n = 1'b1;
  end

endmodule

/* bench/lsu_tb.sv */
// Self-checking testbench for the load/store unit; run as the simulation top.
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_tb import lsu_pkg::*; ();

  localparam int N_REQ       = 256 + 300 + 32 + 4 + 6 + 8;
  localparam int CYC_PER_REQ = 16;
  localparam int LIMIT_CYC   = N_REQ * CYC_PER_REQ + 500;

  logic                 clk;
  logic                 arst_n;
  logic                 i_req_valid;
  lsu_req_t             i_req;
  logic                 o_req_credit;
  logic                 o_rsp_valid;
  lsu_rsp_t             o_rsp;
  logic                 i_rsp_credit;
  logic                 i_cfg_we;
  reg_addr_e            i_cfg_addr;
  logic [`LSU_XLEN-1:0] i_cfg_wdata;
  logic [`LSU_XLEN-1:0] o_cfg_rdata;

  integer     seed = 32'h23fa;
  logic [7:0] model [2048]; // Byte image of the data memory.
  lsu_rsp_t   exp_q [$];
  int         lat_q [$];    // Issue cycle, or -1 when latency is not checked.
  string      cur_test = "reset";
  int         req_cred = `LSU_REQ_DEPTH;
  int         outstanding = 0;
  int         to_return = 0;
  int         rsp_count = 0;
  int         req_pulses = 0;
  int         cyc = 0;
  bit         hold = 0;
  bit         en_shadow = 0;
  bit         time_it = 0;
  logic [3:0] next_tag = 4'd0;

  lsu_clkgen u_clkgen (.o_clk(clk), .o_arst_n(arst_n));

  lsu_top dut (
    .i_clk        (clk),
    .i_arst_n     (arst_n),
    .i_req_valid  (i_req_valid),
    .i_req        (i_req),
    .o_req_credit (o_req_credit),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp        (o_rsp),
    .i_rsp_credit (i_rsp_credit),
    .i_cfg_we     (i_cfg_we),
    .i_cfg_addr   (i_cfg_addr),
    .i_cfg_wdata  (i_cfg_wdata),
    .o_cfg_rdata  (o_cfg_rdata)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Failure reporting and reference rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic expect_equal(input string what, input logic [63:0] exp,
                              input logic [63:0] act);
    assert (exp === act) else
      stop_run($sformatf("** Error %s: %s expected %0h, actual %0h", cur_test, what, exp, act));
  endtask

  function automatic int size_of(input logic [2:0] op);
    case (op)
      3'd0, 3'd1: return 1;
      3'd2, 3'd3: return 2;
      3'd4, 3'd5: return 4;
      3'd6:       return 8;
      default:    return 0;
    endcase
  endfunction

  function automatic bit is_bad(input logic [2:0] op, input logic [63:0] addr);
    int n;
    n = size_of(op);
    return (n == 0) || ((addr % n) != 0);
  endfunction

  function automatic logic [63:0] load_value(input logic [2:0] op, input logic [63:0] addr);
    logic [63:0] v;
    int          n;
    v = '0;
    n = size_of(op);
    for (int i = 0; i < n; i++) v[i*8 +: 8] = model[(addr[10:0] + i) % 2048];
    if ((op == 3'd0 || op == 3'd2 || op == 3'd4) && v[n*8-1]) begin
      for (int b = n * 8; b < 64; b++) v[b] = 1'b1; // Sign fill.
    end
    return v;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_req(input bit st, input logic [2:0] op, input logic [63:0] addr,
                          input logic [63:0] wdata);
    lsu_rsp_t e;
    int       n;
    @(posedge clk);
    #1;
    while (req_cred == 0) begin
      @(posedge clk);
      #1;
    end
    i_req_valid    = 1'b1;
    i_req.is_store = st;
    i_req.op       = mem_op_e'(op);
    i_req.addr     = addr;
    i_req.wdata    = wdata;
    i_req.tag      = next_tag;
    req_cred--;
    e.tag   = next_tag;
    e.fault = is_bad(op, addr);
    e.rdata = (st || e.fault) ? '0 : load_value(op, addr);
    n = size_of(op);
    if (st && !e.fault) begin
      for (int i = 0; i < n; i++) model[addr[10:0] + i] = wdata[i*8 +: 8];
    end
    exp_q.push_back(e);
    lat_q.push_back(time_it ? cyc : -1);
    next_tag++;
    @(posedge clk);
    #1 i_req_valid = 1'b0;
  endtask

  task automatic write_reg(input reg_addr_e a, input logic [63:0] d);
    @(posedge clk);
    #1;
    i_cfg_we    = 1'b1;
    i_cfg_addr  = a;
    i_cfg_wdata = d;
    @(posedge clk);
    #1 i_cfg_we = 1'b0;
    if (a == REG_CTRL) en_shadow = d[0];
  endtask

  task automatic read_reg(input reg_addr_e a, output logic [63:0] d);
    @(posedge clk);
    #1 i_cfg_addr = a;
    #1 d = o_cfg_rdata;
  endtask

  task automatic drain;
    while (exp_q.size() != 0 || outstanding != 0) @(posedge clk);
  endtask

  // Returns response credits one at a time after a random wait.
  initial begin
    i_rsp_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1 i_rsp_credit = 1'b0;
      if (!hold && to_return > 0 && $random(seed) % 2 == 0) begin
        i_rsp_credit = 1'b1;
        to_return--;
      end
    end
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    lsu_rsp_t e;
    int       t0;
    if (arst_n) begin
      if (i_rsp_credit) outstanding--;
      if (o_req_credit) begin
        req_cred++;
        req_pulses++;
      end
      if (o_rsp_valid) begin
        assert (exp_q.size() != 0) else stop_run("Response came out with none expected.");
        e  = exp_q.pop_front();
        t0 = lat_q.pop_front();
        expect_equal("tag", 64'(e.tag), 64'(o_rsp.tag));
        expect_equal("fault", 64'(e.fault), 64'(o_rsp.fault));
        expect_equal("rdata", e.rdata, o_rsp.rdata);
        if (t0 >= 0) expect_equal("latency", 64'd3, 64'(cyc - t0));
        rsp_count++;
        outstanding++;
        to_return++;
        assert (outstanding <= `LSU_RSP_CREDITS) else
          stop_run("More responses are uncredited than the unit holds credits.");
      end
    end
  end

  // A disabled unit must stay silent.
  assert property (@(negedge clk) disable iff (!arst_n) o_rsp_valid |-> en_shadow)
    else stop_run("Response came out while the unit was disabled.");

  initial begin
    repeat (LIMIT_CYC) @(posedge clk);
    $display("Watchdog expired before the tests completed.");
    $display("Finished with errors");
    $fatal(1);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [63:0] a;
    logic [63:0] d;
    logic [2:0]  op;
    int          n;
    logic [63:0] fault_addrs [$];
    i_req_valid = 1'b0;
    i_req       = '0;
    i_cfg_we    = 1'b0;
    i_cfg_addr  = REG_CTRL;
    i_cfg_wdata = '0;
    @(posedge arst_n);
    write_reg(REG_CTRL, 64'd1);
    read_reg(REG_CTRL, d);
    expect_equal("enable readback", 64'd1, d);

    cur_test = "preload";
    for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
      a = 64'(w * 8);
      send_req(1'b1, 3'd6, a, {a[31:0] ^ 32'hc3a5_0f1e, a[31:0] * 32'h0101_0103});
    end

    cur_test = "round_trip";
    for (int i = 0; i < 300; i++) begin
      op = 3'($unsigned($random(seed)) % 7);
      n  = size_of(op);
      a  = {$random(seed), $random(seed)};
      a  = a & ~64'(n - 1);
      send_req($random(seed) % 2 == 0, op, a, {$random(seed), $random(seed)});
    end

    cur_test = "faults";
    drain();
    for (int i = 0; i < 16; i++) begin
      op = ($unsigned($random(seed)) % 4 == 0) ? 3'd7 : 3'(2 + $unsigned($random(seed)) % 5);
      a  = {$random(seed), $random(seed)} | 64'd1;
      send_req($random(seed) % 2 == 0, op, a, {$random(seed), $random(seed)});
      fault_addrs.push_back(a);
      drain();
      read_reg(REG_FAULT_CNT, d);
      expect_equal("fault count", 64'(i + 1), d);
      read_reg(REG_FAULT_ADDR, d);
      expect_equal("fault address", a, d);
    end
    foreach (fault_addrs[i]) send_req(1'b0, 3'd6, fault_addrs[i] & ~64'd7, '0);

    cur_test = "disabled";
    drain();
    write_reg(REG_CTRL, 64'd0);
    read_reg(REG_CTRL, d);
    expect_equal("enable readback", 64'd0, d);
    for (int i = 0; i < 4; i++) send_req(1'b0, 3'd1, 64'(i * 9), '0);
    repeat (20) @(posedge clk);
    write_reg(REG_CTRL, 64'd1);

    cur_test = "back_pressure";
    drain();
    hold = 1;
    for (int i = 0; i < 6; i++) send_req(1'b0, 3'd6, 64'(i * 8), '0);
    repeat (20) @(posedge clk);
    expect_equal("uncredited responses", `LSU_RSP_CREDITS, 64'(outstanding));
    expect_equal("waiting requests", 64'd4, 64'(exp_q.size()));
    expect_equal("request credits", 64'd0, 64'(req_cred));
    hold = 0;

    cur_test = "idle_latency";
    drain();
    time_it = 1;
    for (int i = 0; i < 8; i++) begin
      send_req(i % 2 == 0, 3'(i % 7), 64'(i * 8), {$random(seed), $random(seed)});
      drain();
    end
    time_it = 0;

    cur_test = "credit_count";
    repeat (4) @(posedge clk);
    expect_equal("request credit pulses", 64'(rsp_count), 64'(req_pulses));
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_req_fifo.sv
src/lsu_align.sv
src/lsu_ctrl.sv
src/lsu_dmem.sv
src/lsu_regs.sv
src/lsu_top.sv
bench/lsu_clkgen.sv
bench/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; exit status reflects the result.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module lsu_tb -f filelist.f &&
./obj_dir/Vlsu_tb | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
